// File: panel_scanner.sv
/* indicator panel scanner, a read-only master on the register bus
   each frame reads the configuration, then shifts count+1 panels out msb first
   and ends with one panel clock period of latch */
`timescale 1ns/100ps

module panel_scanner #(
   parameter int scan_div = 50   // half period of panel_clk in clk20 cycles
) (
   input  logic                                 clk20,
   input  logic                                 rst,
   input  logic                                 wb_ack,
   input  logic [qsic_pkg::data_width-1:0]      wb_dat_r,
   output logic                                 wb_cyc,
   output logic                                 wb_stb,
   output logic                                 wb_we,
   output logic [qsic_pkg::wb_addr_width-1:0]   wb_adr,
   output logic                                 panel_clk,
   output logic                                 panel_latch,
   output logic                                 panel_out
);
   import qsic_pkg::*;

   typedef enum logic [1:0] {st_conf, st_load, st_shift, st_latch} state_t;

   state_t                        state;
   logic [$clog2(scan_div+1)-1:0] div_cnt;
   logic                          tick;
   logic [$clog2(panel_bits)-1:0] bit_cnt;
   logic [1:0]                    count;
   logic [1:0]                    step;
   logic [1:0]                    list [0:3];
   logic [1:0]                    sel;   // panel of the current step
   logic [panel_bits-1:0]         shreg;

   assign sel = list[step];
   assign tick = div_cnt == scan_div - 1;

   // lamptest needs no bus access
   assign wb_cyc = state == st_conf || (state == st_load && sel != 2'd0);
   assign wb_stb = wb_cyc;
   assign wb_we = 1'b0;
   assign wb_adr = (state == st_conf) ? conf_idx : sel;   // panel n shows display word n
   assign panel_out = shreg[panel_bits-1];

   always_ff @(posedge clk20) begin
      if (rst) begin
         state <= st_conf;
         div_cnt <= '0;
         bit_cnt <= '0;
         step <= '0;
         panel_clk <= 1'b0;
         panel_latch <= 1'b0;
      end else begin
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
         case (state)
            st_conf:
               if (wb_ack) begin
                  step <= '0;
                  state <= st_load;
               end
            st_load:
               if (sel == 2'd0 || wb_ack) begin
                  div_cnt <= '0;   // full low half period before the first rise
                  bit_cnt <= '0;
                  state <= st_shift;
               end
            st_shift:
               if (tick) begin
                  panel_clk <= ~panel_clk;
                  if (panel_clk) begin   // falling edge, next bit
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == panel_bits - 1) begin
                        step <= step + 1'b1;
                        if (step == count) begin
                           panel_latch <= 1'b1;
                           state <= st_latch;
                        end else begin
                           state <= st_load;
                        end
                     end
                  end
               end
            default:
               // bit_cnt wrapped to 0, two ticks make one clock period
               if (tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt[0]) begin
                     panel_latch <= 1'b0;
                     state <= st_conf;
                  end
               end
         endcase
      end
   end

   always_ff @(posedge clk20) begin
      if (state == st_conf && wb_ack) begin
         count <= wb_dat_r[conf_count_lsb +: 2];
         for (int i = 0; i < 4; i++)
            list[i] <= wb_dat_r[conf_list_stride*i +: 2];
      end
      if (state == st_load)
         shreg <= (sel == 2'd0) ? lamptest_word : wb_dat_r;
      else if (state == st_shift && tick && panel_clk)
         shreg <= shreg << 1;
   end

endmodule

// File: qbus_slave.sv
/* qbus slave cycle sequencer for the register block
   decodes the latched address, runs one register bus access per strobe
   and answers with trply, plus the read word on dal_out */
`timescale 1ns/100ps

module qbus_slave #(
   parameter logic [qsic_pkg::reg_off_width-1:0] base_offset = 13'o17720
) (
   input  logic                                 clk20,
   input  logic                                 rst,
   input  logic                                 s_rsync,
   input  logic                                 s_rdin,
   input  logic                                 s_rdout,
   input  logic                                 rdin_rise,
   input  logic                                 rdout_rise,
   input  qsic_pkg::dal_word_t                  addr,
   input  logic                                 addr_bs7,
   input  qsic_pkg::dal_word_t                  dal_in,
   input  logic                                 wb_ack,
   input  logic [qsic_pkg::data_width-1:0]      wb_dat_r,
   output logic                                 wb_cyc,
   output logic                                 wb_stb,
   output logic                                 wb_we,
   output logic [qsic_pkg::wb_addr_width-1:0]   wb_adr,
   output logic [qsic_pkg::data_width-1:0]      wb_dat_w,
   output logic                                 trply,
   output qsic_pkg::dal_word_t                  dal_out,
   output logic                                 dal_tx
);
   import qsic_pkg::*;

   localparam int blk_lsb = wb_addr_width + 1;   // block spans four words

   typedef enum logic [1:0] {st_idle, st_bus, st_reply} state_t;

   state_t state;
   logic   hit;
   logic   start;

   assign hit = addr_bs7 && s_rsync &&
                addr.a.offset[reg_off_width-1:blk_lsb] == base_offset[reg_off_width-1:blk_lsb];
   assign start = state == st_idle && (rdin_rise || rdout_rise);

   always_ff @(posedge clk20) begin
      if (rst) begin
         state <= st_idle;
         trply <= 1'b0;
         dal_tx <= 1'b0;
      end else begin
         case (state)
            st_idle:
               if (start && hit)
                  state <= st_bus;   // other addresses stay unanswered
            st_bus:
               if (wb_ack) begin
                  trply <= 1'b1;
                  dal_tx <= ~wb_we;
                  state <= st_reply;
               end
            default:
               // hold the reply until the host lets go of its strobe
               if (!s_rdin && !s_rdout) begin
                  trply <= 1'b0;
                  dal_tx <= 1'b0;
                  state <= st_idle;
               end
         endcase
      end
   end

   always_ff @(posedge clk20) begin
      if (start) begin
         wb_we <= rdout_rise;
         wb_adr <= addr.a.offset[wb_addr_width:1];   // byte offset to word index
         wb_dat_w <= dal_in.d.data;
      end
      if (state == st_bus && wb_ack && !wb_we)
         dal_out.d <= {{(dal_width-data_width){1'b0}}, wb_dat_r};
   end

   // cyc drops the cycle after ack as the state moves on
   assign wb_cyc = state == st_bus;
   assign wb_stb = wb_cyc;

   a_reply_after_ack: assert property (@(posedge clk20) disable iff (rst)
      $rose(trply) |-> $past(wb_ack));

endmodule

// File: qbus_sync.sv
/* brings rsync, rdin and rdout into the clk20 domain
   gives synced levels, rise pulses for the data strobes and the cycle address,
   latched when rsync is seen rising */
`timescale 1ns/100ps

module qbus_sync (
   input  logic                clk20,
   input  logic                rst,
   input  logic                rsync,
   input  logic                rdin,
   input  logic                rdout,
   input  logic                bs7,
   input  qsic_pkg::dal_word_t dal_in,
   output logic                s_rsync,
   output logic                s_rdin,
   output logic                s_rdout,
   output logic                rdin_rise,
   output logic                rdout_rise,
   output qsic_pkg::dal_word_t addr,
   output logic                addr_bs7
);

   logic [2:0] meta;   // bit 2 rsync, bit 1 rdin, bit 0 rdout
   logic [2:0] sync;
   logic [2:0] last;   // edge stage
   logic [2:0] rise;

   always_ff @(posedge clk20) begin
      if (rst) begin
         meta <= '0;
         sync <= '0;
         last <= '0;
      end else begin
         meta <= {rsync, rdin, rdout};
         sync <= meta;
         last <= sync;
      end
   end

   assign rise = sync & ~last;
   assign {s_rsync, s_rdin, s_rdout} = sync;
   assign rdin_rise = rise[1];
   assign rdout_rise = rise[0];

   // host still holds the address here
   always_ff @(posedge clk20) begin
      if (rise[2]) begin
         addr.a <= dal_in.a;
         addr_bs7 <= bs7;
      end
   end

   // a DATI and a DATO never overlap on the bus
   a_one_strobe: assert property (@(posedge clk20) disable iff (rst) !(s_rdin && s_rdout));

endmodule

// File: qsic_pkg.sv
/* shared definitions for the qbus register block and the panel scanner
   import into module bodies, or use scoped names in module headers */
package qsic_pkg;

   localparam int dal_width = 22;
   localparam int data_width = 16;
   localparam int reg_off_width = 13;   // i/o page offset
   localparam int wb_addr_width = 2;    // word index on the register bus

   localparam logic [wb_addr_width-1:0] conf_idx = 2'd0;
   localparam logic [wb_addr_width-1:0] disp1_idx = 2'd1;
   localparam logic [wb_addr_width-1:0] disp2_idx = 2'd2;
   localparam logic [wb_addr_width-1:0] disp3_idx = 2'd3;

   // configuration word: count in 13:12, list entry i in bits 3*i+1:3*i
   localparam int conf_count_lsb = 12;
   localparam int conf_list_stride = 3;
   localparam logic [data_width-1:0] conf_mask = 16'b00_11_0_11_0_11_0_11_0_11;
   localparam logic [data_width-1:0] conf_reset = 16'b00_10_0_10_0_01_0_00_0_01;

   // panel 0 lights every lamp
   localparam logic [data_width-1:0] lamptest_word = 16'hffff;
   localparam int panel_bits = 16;

   // the same dal lines carry the address, then the data
   typedef union packed {
      struct packed {
         logic [dal_width-reg_off_width-1:0] page;
         logic [reg_off_width-1:0]           offset;
      } a;
      struct packed {
         logic [dal_width-data_width-1:0] unused;
         logic [data_width-1:0]           data;
      } d;
   } dal_word_t;

endpackage

// File: qsic_regs.sv
/* register file on the internal wishbone bus
   word 0 is the panel configuration, words 1 to 3 the display words */
`timescale 1ns/100ps

module qsic_regs (
   input  logic                                 clk20,
   input  logic                                 rst,
   input  logic                                 cyc,
   input  logic                                 stb,
   input  logic                                 we,
   input  logic [qsic_pkg::wb_addr_width-1:0]   adr,
   input  logic [qsic_pkg::data_width-1:0]      dat_w,
   output logic                                 ack,
   output logic [qsic_pkg::data_width-1:0]      dat_r
);
   import qsic_pkg::*;

   logic [data_width-1:0] regs [0:2**wb_addr_width-1];
   logic                  req;

   assign req = cyc && stb && !ack;   // one ack per request

   always_ff @(posedge clk20) begin
      if (rst) begin
         ack <= 1'b0;
         regs[conf_idx] <= conf_reset;   // count 2, list 1 0 1 2
         regs[disp1_idx] <= '0;
         regs[disp2_idx] <= '0;
         regs[disp3_idx] <= '0;
      end else begin
         ack <= req;
         if (req && we) begin
            // undefined configuration bits are not stored
            if (adr == conf_idx)
               regs[adr] <= dat_w & conf_mask;
            else
               regs[adr] <= dat_w;
         end
      end
   end

   assign dat_r = regs[adr];   // stable by the ack, adr is held

endmodule

// File: qsic_top.sv
/* qbus peripheral with the panel configuration register and three display words
   qbus slave and panel scanner share the register file through the arbiter */
`timescale 1ns/100ps

module qsic_top #(
   parameter logic [qsic_pkg::reg_off_width-1:0] base_offset = 13'o17720,
   parameter int scan_div = 50
) (
   input  logic                clk20,
   input  logic                rst,
   input  logic                rsync,
   input  logic                rdin,
   input  logic                rdout,
   input  logic                bs7,
   input  logic                wtbt,   // word-only block, byte writes not decoded
   input  qsic_pkg::dal_word_t dal_in,
   output qsic_pkg::dal_word_t dal_out,
   output logic                dal_tx,
   output logic                trply,
   output logic                panel_clk,
   output logic                panel_latch,
   output logic                panel_out
);
   import qsic_pkg::*;

   logic                     s_rsync;
   logic                     s_rdin;
   logic                     s_rdout;
   logic                     rdin_rise;
   logic                     rdout_rise;
   dal_word_t                addr;
   logic                     addr_bs7;
   logic                     m0_cyc;
   logic                     m0_stb;
   logic                     m0_we;
   logic [wb_addr_width-1:0] m0_adr;
   logic [data_width-1:0]    m0_dat_w;
   logic                     m0_ack;
   logic                     m1_cyc;
   logic                     m1_stb;
   logic                     m1_we;
   logic [wb_addr_width-1:0] m1_adr;
   logic                     m1_ack;
   logic [data_width-1:0]    m_dat_r;
   logic                     s_cyc;
   logic                     s_stb;
   logic                     s_we;
   logic [wb_addr_width-1:0] s_adr;
   logic [data_width-1:0]    s_dat_w;
   logic                     s_ack;
   logic [data_width-1:0]    s_dat_r;

   qbus_sync qbus_sync_i (
      .clk20(clk20), .rst(rst), .rsync(rsync), .rdin(rdin), .rdout(rdout),
      .bs7(bs7), .dal_in(dal_in), .s_rsync(s_rsync), .s_rdin(s_rdin),
      .s_rdout(s_rdout), .rdin_rise(rdin_rise), .rdout_rise(rdout_rise),
      .addr(addr), .addr_bs7(addr_bs7));

   qbus_slave #(.base_offset(base_offset)) qbus_slave_i (
      .clk20(clk20), .rst(rst), .s_rsync(s_rsync), .s_rdin(s_rdin),
      .s_rdout(s_rdout), .rdin_rise(rdin_rise), .rdout_rise(rdout_rise),
      .addr(addr), .addr_bs7(addr_bs7), .dal_in(dal_in), .wb_ack(m0_ack),
      .wb_dat_r(m_dat_r), .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_we(m0_we),
      .wb_adr(m0_adr), .wb_dat_w(m0_dat_w), .trply(trply), .dal_out(dal_out),
      .dal_tx(dal_tx));

   // scanner only reads, its write data is tied off
   wb_arbiter wb_arbiter_i (
      .clk20(clk20), .rst(rst),
      .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_we(m0_we), .m0_adr(m0_adr),
      .m0_dat_w(m0_dat_w), .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_we(m1_we),
      .m1_adr(m1_adr), .m1_dat_w('0), .s_ack(s_ack), .s_dat_r(s_dat_r),
      .m0_ack(m0_ack), .m1_ack(m1_ack), .m_dat_r(m_dat_r), .s_cyc(s_cyc),
      .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr), .s_dat_w(s_dat_w));

   qsic_regs qsic_regs_i (
      .clk20(clk20), .rst(rst), .cyc(s_cyc), .stb(s_stb), .we(s_we),
      .adr(s_adr), .dat_w(s_dat_w), .ack(s_ack), .dat_r(s_dat_r));

   panel_scanner #(.scan_div(scan_div)) panel_scanner_i (
      .clk20(clk20), .rst(rst), .wb_ack(m1_ack), .wb_dat_r(m_dat_r),
      .wb_cyc(m1_cyc), .wb_stb(m1_stb), .wb_we(m1_we), .wb_adr(m1_adr),
      .panel_clk(panel_clk), .panel_latch(panel_latch), .panel_out(panel_out));

endmodule

// File: tb.f
qsic_pkg.sv
qbus_sync.sv
qbus_slave.sv
wb_arbiter.sv
qsic_regs.sv
panel_scanner.sv
qsic_top.sv
tb_qsic.sv

// File: tb_qsic.sv
/* testbench for the qbus register block and the panel scanner
   runs random DATI and DATO cycles against a register model and
   checks captured panel frames against a frame model */
`timescale 1ns/100ps

module tb_qsic;
   import qsic_pkg::*;

   localparam logic [12:0] base_offset = 13'o17720;
   localparam int scan_div = 2;
   localparam int clk_period = 10;
   localparam int n_random = 200;
   localparam int n_conf = 4;          // configuration writes with a frame check each
   localparam int reply_wait = 60;     // cycles allowed for trply to move
   localparam int miss_wait = 40;      // cycles a missed address must stay unanswered
   localparam int n_host = 13 + n_random + 2 * n_conf;
   localparam int host_bound = 100;
   // two frames of four panels may pass before a full one is captured
   localparam int frame_bound = 2 * (4 * 16 * 2 * scan_div + 40);
   localparam int n_frames = 1 + n_conf;
   localparam int timeout_cycles = n_host * host_bound + n_frames * frame_bound + 100;

   logic      clk20;
   logic      rst;
   logic      rsync;
   logic      rdin;
   logic      rdout;
   logic      bs7;
   logic      wtbt;
   dal_word_t dal_in;
   dal_word_t dal_out;
   logic      dal_tx;
   logic      trply;
   logic      panel_clk;
   logic      panel_latch;
   logic      panel_out;

   logic [15:0] model [0:3];
   bit          in_read;   // a read cycle the DUT may answer

   qsic_top #(.base_offset(base_offset), .scan_div(scan_div)) qsic_top_i (
      .clk20(clk20), .rst(rst), .rsync(rsync), .rdin(rdin), .rdout(rdout),
      .bs7(bs7), .wtbt(wtbt), .dal_in(dal_in), .dal_out(dal_out), .dal_tx(dal_tx),
      .trply(trply), .panel_clk(panel_clk), .panel_latch(panel_latch),
      .panel_out(panel_out));

   always #(clk_period / 2) clk20 = ~clk20;

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   // count in bits 13:12, list entry i in bits 3*i+1:3*i
   function automatic logic [15:0] conf_word(input int count, input int l0, input int l1,
                                             input int l2, input int l3);
      logic [15:0] w;
      w = '0;
      w[13:12] = count[1:0];
      w[1:0] = l0[1:0];
      w[4:3] = l1[1:0];
      w[7:6] = l2[1:0];
      w[10:9] = l3[1:0];
      return w;
   endfunction

   task automatic model_reset();
      model[0] = conf_word(2, 1, 0, 1, 2);
      model[1] = '0;
      model[2] = '0;
      model[3] = '0;
   endtask

   task automatic model_write(input int idx, input logic [15:0] data);
      if (idx == 0)
         model[0] = data & conf_word(3, 3, 3, 3, 3);   // only the defined fields
      else
         model[idx] = data;
   endtask

   task automatic expected_frame(output logic [63:0] bits, output int nbits);
      int count;
      int sel;
      bits = '0;
      nbits = 0;
      count = model[0][13:12];
      for (int step = 0; step <= count; step++) begin
         sel = model[0][3*step +: 2];
         bits = {bits[47:0], (sel == 0) ? 16'hffff : model[sel]};   // panel 0 is lamptest
         nbits += 16;
      end
   endtask

   // one DATI or DATO; answer says whether the address lies in the block
   task automatic host_cycle(input bit write, input logic [12:0] off,
                             input logic [15:0] wdata, input bit answer,
                             output logic [15:0] rdata);
      dal_word_t word;
      int        waited;
      word = '0;
      word.a.page = '1;
      word.a.offset = off;
      rdata = '0;
      @(posedge clk20);
      dal_in <= word;
      bs7 <= 1'b1;
      @(posedge clk20);
      rsync <= 1'b1;
      repeat (4) @(posedge clk20);   // address held past the latch
      word = '0;
      if (write) begin
         word.d.data = wdata;
         dal_in <= word;
         rdout <= 1'b1;
      end else begin
         dal_in <= word;
         rdin <= 1'b1;
         in_read = answer;
      end
      waited = 0;
      @(negedge clk20);
      if (answer) begin
         while (!trply && waited < reply_wait) begin
            @(negedge clk20);
            waited++;
         end
         if (!trply) begin
            $display("no trply from the DUT for offset %o", off);
            abort_run();
         end
         check_value("reply dal_tx", !write, dal_tx);
         rdata = dal_out.d.data;
      end else begin
         repeat (miss_wait) begin
            check_value("miss trply", 0, trply);
            @(negedge clk20);
         end
      end
      @(posedge clk20);
      rdin <= 1'b0;
      rdout <= 1'b0;
      if (answer) begin
         @(negedge clk20);
         check_value("trply hold", 1, trply);   // strobe fall still in the synchronizer
         waited = 0;
         while (trply && waited < reply_wait) begin
            @(negedge clk20);
            waited++;
         end
         if (trply) begin
            $display("trply stayed high after the strobe was released at offset %o", off);
            abort_run();
         end
      end
      in_read = 1'b0;
      @(posedge clk20);
      rsync <= 1'b0;
      bs7 <= 1'b0;
      dal_in <= '0;
   endtask

   task automatic reg_write(input int idx, input logic [15:0] data);
      logic [15:0] unused;
      host_cycle(1'b1, base_offset + 13'(2 * idx), data, 1'b1, unused);
      model_write(idx, data);
   endtask

   task automatic reg_read(input int idx, output logic [15:0] data);
      host_cycle(1'b0, base_offset + 13'(2 * idx), '0, 1'b1, data);
   endtask

   // frame between two latches, bits taken at each rising panel clock
   task automatic capture_frame(output logic [63:0] bits, output int nbits);
      logic prev_clk;
      bits = '0;
      nbits = 0;
      @(negedge clk20);
      while (!panel_latch)
         @(negedge clk20);
      while (panel_latch)
         @(negedge clk20);
      prev_clk = panel_clk;
      while (!panel_latch) begin
         if (panel_clk && !prev_clk) begin
            if (nbits == 64) begin
               $display("panel frame is longer than four panels");
               abort_run();
            end
            bits = {bits[62:0], panel_out};
            nbits++;
         end
         prev_clk = panel_clk;
         @(negedge clk20);
      end
   endtask

   task automatic frame_check(input string name);
      logic [63:0] exp_bits;
      logic [63:0] got_bits;
      int          exp_n;
      int          got_n;
      capture_frame(got_bits, got_n);
      expected_frame(exp_bits, exp_n);
      check_value({name, " length"}, exp_n, got_n);
      check_value({name, " bits"}, exp_bits, got_bits);
   endtask

   // dal_tx belongs to read cycles only
   always @(negedge clk20) begin
      if (!rst && !in_read)
         check_value("dal_tx idle", 0, dal_tx);
   end

   initial begin
      #(timeout_cycles * clk_period);
      $display("watchdog expired, the tests ran longer than their bound");
      abort_run();
   end

   initial begin
      logic [15:0] rdata;
      logic [15:0] wdata;
      logic [12:0] off;
      int          idx;
      void'($urandom(32'h78e4));
      clk20 = 1'b0;
      rst = 1'b1;
      rsync = 1'b0;
      rdin = 1'b0;
      rdout = 1'b0;
      bs7 = 1'b0;
      wtbt = 1'b0;
      dal_in = '0;
      in_read = 1'b0;
      model_reset();
      repeat (4) @(posedge clk20);
      rst <= 1'b0;

      for (int i = 0; i < 4; i++) begin
         reg_read(i, rdata);
         check_value("reset read", model[i], rdata);
      end

      for (int i = 0; i < n_random; i++) begin
         idx = $urandom % 4;
         if ($urandom % 2) begin
            wdata = $urandom;
            reg_write(idx, wdata);
         end else begin
            reg_read(idx, rdata);
            check_value("random read", model[idx], rdata);
         end
      end
      for (int i = 0; i < 4; i++) begin
         reg_read(i, rdata);
         check_value("random readback", model[i], rdata);
      end

      frame_check("idle frame");

      do
         off = $urandom;
      while (off[12:3] == base_offset[12:3]);
      host_cycle($urandom % 2, off, $urandom, 1'b0, rdata);
      for (int i = 0; i < 4; i++) begin
         reg_read(i, rdata);
         check_value("miss readback", model[i], rdata);
      end

      for (int i = 0; i < n_conf; i++) begin
         wdata = $urandom;
         reg_write(0, wdata);
         reg_read(0, rdata);
         check_value("conf readback", model[0], rdata);
         frame_check("conf frame");
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

// File: wb_arbiter.sv
/* fixed priority arbiter for two wishbone classic masters on one slave
   master 0 wins an idle bus, a grant is held until its owner drops cyc */
`timescale 1ns/100ps

module wb_arbiter (
   input  logic                                 clk20,
   input  logic                                 rst,
   input  logic                                 m0_cyc,
   input  logic                                 m0_stb,
   input  logic                                 m0_we,
   input  logic [qsic_pkg::wb_addr_width-1:0]   m0_adr,
   input  logic [qsic_pkg::data_width-1:0]      m0_dat_w,
   input  logic                                 m1_cyc,
   input  logic                                 m1_stb,
   input  logic                                 m1_we,
   input  logic [qsic_pkg::wb_addr_width-1:0]   m1_adr,
   input  logic [qsic_pkg::data_width-1:0]      m1_dat_w,
   input  logic                                 s_ack,
   input  logic [qsic_pkg::data_width-1:0]      s_dat_r,
   output logic                                 m0_ack,
   output logic                                 m1_ack,
   output logic [qsic_pkg::data_width-1:0]      m_dat_r,
   output logic                                 s_cyc,
   output logic                                 s_stb,
   output logic                                 s_we,
   output logic [qsic_pkg::wb_addr_width-1:0]   s_adr,
   output logic [qsic_pkg::data_width-1:0]      s_dat_w
);

   logic busy;    // a grant is held
   logic owner;   // holder of the grant
   logic sel;     // master routed to the slave this cycle

   // an idle bus goes straight to the requester, no extra cycle
   assign sel = busy ? owner : ~m0_cyc;

   always_ff @(posedge clk20) begin
      if (rst) begin
         busy <= 1'b0;
         owner <= 1'b0;
      end else if (!busy) begin
         busy <= m0_cyc || m1_cyc;
         owner <= sel;
      end else if (!s_cyc) begin
         busy <= 1'b0;   // owner finished
      end
   end

   assign s_cyc = sel ? m1_cyc : m0_cyc;
   assign s_stb = sel ? m1_stb : m0_stb;
   assign s_we = sel ? m1_we : m0_we;
   assign s_adr = sel ? m1_adr : m0_adr;
   assign s_dat_w = sel ? m1_dat_w : m0_dat_w;

   assign m0_ack = s_ack & ~sel;
   assign m1_ack = s_ack & sel;
   assign m_dat_r = s_dat_r;

   // slave acks arrive a cycle after the request, so the grant is registered by then
   a_ack_owner: assert property (@(posedge clk20) disable iff (rst)
      (m0_ack || m1_ack) |-> busy && owner == m1_ack);

endmodule
